/* Bender.yml */
package:
  name: branch_predict

sources:
  # packages first, then leaf modules, then the top level
  - files:
      - verilog/fetchPkg.sv
      - verilog/predictorPkg.sv
      - verilog/historyRam.sv
      - verilog/globalHistoryReg.sv
      - verilog/globalHistoryTable.sv
      - verilog/branchPredictTop.sv

  # testbench, top module tbBranchPredict
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/tbBranchPredict.sv

/* build.f */
verilog/fetchPkg.sv
verilog/predictorPkg.sv
verilog/historyRam.sv
verilog/globalHistoryReg.sv
verilog/globalHistoryTable.sv
verilog/branchPredictTop.sv
sim/clockGen.sv
sim/tbBranchPredict.sv

/* sim/clockGen.sv */
/*
 * Testbench clock and reset source.
 * Free-running clock; reset held low for a fixed number of edges.
 */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release 1 ns after the last reset edge, like the other inputs
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tbBranchPredict.sv */
/*
 * Testbench of the branch predictor top level.
 * Directed lookups and repairs, then a seeded random mix; a model of the
 * tables and history predicts every response and a mid-cycle check compares.
 */
`timescale 1ns/10ps
`default_nettype none

module tbBranchPredict
    import fetchPkg::*;
    import predictorPkg::*;
;

    localparam int HIST_LEN        = 4;
    localparam int TABLE_ENTRIES   = 256;
    localparam int IDX_W           = $clog2(TABLE_ENTRIES);
    localparam int PC_BITS         = IDX_W - HIST_LEN;
    localparam int ENTRY_BITS      = CTR_W + TARGET_W;
    localparam int CKPT_W          = HIST_LEN + 1 + ENTRY_BITS;
    localparam int RESP_W          = SLOT_NUM + SLOT_NUM * ADDR_W + SLOT_NUM * CKPT_W;
    localparam int CLK_PERIOD_NS   = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 200;
    localparam int RANDOM_CYCLES   = 400;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;

    localparam logic [ADDR_W-1:0] BLOCK_A    = 32'h0000_1230;
    localparam logic [ADDR_W-1:0] FILLER     = 32'h0000_20F0;
    localparam logic [ADDR_W-1:0] RAND_BASE  = 32'h0004_0000;
    localparam logic [ADDR_W-1:0] TARGET_ONE = 32'h0000_8000;
    // a direction repair on a valid entry must not take this destination
    localparam logic [ADDR_W-1:0] OTHER_DEST = 32'h0000_9F00;
    // counter step directions form a palindrome so bit order does not matter
    localparam logic [7:0]        STEP_DIR   = 8'b1100_0011;

    logic clk, rst;
    logic lookupReq, indexOk, repairValid, repairTaken, lookupValid;
    logic [ADDR_W-1:0] fetchAddr, repairPc, repairDest;
    logic [ACT_W-1:0] repairAction;
    logic [CKPT_W-1:0] repairCheckpoint;
    logic [SLOT_NUM-1:0] predTake;
    logic [SLOT_NUM*ADDR_W-1:0] predDest;
    logic [SLOT_NUM*CKPT_W-1:0] checkpoint;

    // model state
    bit modelValid [SLOT_NUM][TABLE_ENTRIES];
    bit [CTR_W-1:0] modelCtr [SLOT_NUM][TABLE_ENTRIES];
    bit [TARGET_W-1:0] modelTarget [SLOT_NUM][TABLE_ENTRIES];
    logic [HIST_LEN-1:0] modelGhr;
    logic respPending, respTakeOr, acceptNow;
    logic [RESP_W-1:0] newResp, expResp;
    logic [RESP_W-1:0] expQ [$];
    logic [CKPT_W-1:0] lastCkpt [SLOT_NUM];
    logic [ADDR_W-1:0] lastBlock;
    logic [SLOT_NUM*CKPT_W-1:0] expCkpt, ckMask;
    int checkedCount;

    clockGen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clockGen_i (
        .clk (clk),
        .rst (rst)
    );

    branchPredictTop #(.HIST_LEN(HIST_LEN), .TABLE_ENTRIES(TABLE_ENTRIES)) branchPredictTop_i (
        .clk(clk), .rst(rst), .lookupReq_i(lookupReq), .indexOk_i(indexOk),
        .fetchAddr_i(fetchAddr), .repairValid_i(repairValid), .repairAction_i(repairAction),
        .repairCheckpoint_i(repairCheckpoint), .repairPc_i(repairPc),
        .repairTaken_i(repairTaken), .repairDest_i(repairDest), .lookupValid_o(lookupValid),
        .predTake_o(predTake), .predDest_o(predDest), .checkpoint_o(checkpoint)
    );

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    // --------------------
    // reference model
    // --------------------

    // expected {taken bits, destinations, checkpoints} for one block lookup
    function automatic logic [RESP_W-1:0] predictBlock(input logic [ADDR_W-1:0] addr,
                                                       input logic [HIST_LEN-1:0] hist);
        logic [SLOT_NUM-1:0] take;
        logic [SLOT_NUM*ADDR_W-1:0] dest;
        logic [SLOT_NUM*CKPT_W-1:0] ckpt;
        logic [IDX_W-1:0] idx;
        logic [ADDR_W-1:0] slotAddr;
        idx = {hist, addr[BLOCK_LSB +: PC_BITS]};
        for (int k = 0; k < SLOT_NUM; k++) begin
            slotAddr = {addr[ADDR_W-1:BLOCK_LSB], {BLOCK_LSB{1'b0}}} + ADDR_W'(k * 4);
            take[k] = modelValid[k][idx] && modelCtr[k][idx][CTR_W-1];
            dest[k*ADDR_W +: ADDR_W] = take[k] ? {modelTarget[k][idx], 2'b00} : slotAddr + 32'd4;
            ckpt[k*CKPT_W +: CKPT_W] = {hist, modelValid[k][idx], modelCtr[k][idx],
                                        modelTarget[k][idx]};
        end
        return {take, dest, ckpt};
    endfunction

    // entry fields of never-written slots are unknown in the RAM
    function automatic logic [SLOT_NUM*CKPT_W-1:0] ckptMask(input logic [SLOT_NUM*CKPT_W-1:0] ck);
        logic [SLOT_NUM*CKPT_W-1:0] m;
        m = '1;
        for (int k = 0; k < SLOT_NUM; k++) begin
            if (!ck[k*CKPT_W + ENTRY_BITS]) begin
                m[k*CKPT_W +: ENTRY_BITS] = '0;
            end
        end
        return m;
    endfunction

    task automatic trainModel(input logic [ACT_W-1:0] act, input logic [CKPT_W-1:0] ck,
                              input logic [ADDR_W-1:0] pc, input logic tk,
                              input logic [ADDR_W-1:0] dst);
        logic [IDX_W-1:0] idx;
        logic [CTR_W-1:0] ctr;
        logic [TARGET_W-1:0] tgt;
        int bank;
        bank = pc[3:2];
        idx = {ck[CKPT_W-1 -: HIST_LEN], pc[BLOCK_LSB +: PC_BITS]};
        ctr = ck[TARGET_W +: CTR_W];
        tgt = ck[TARGET_W-1:0];
        if (act == ACT_TARGET) begin
            ctr = CTR_WEAK_TAKEN;
            tgt = dst[ADDR_W-1:2];
        end else if (!ck[ENTRY_BITS]) begin
            ctr = tk ? CTR_WEAK_TAKEN : CTR_WEAK_NOT;
            tgt = dst[ADDR_W-1:2];
        end else if (tk) begin
            ctr = (ctr == 2'b11) ? 2'b11 : ctr + 2'b01;
        end else begin
            ctr = (ctr == 2'b00) ? 2'b00 : ctr - 2'b01;
        end
        modelCtr[bank][idx] = ctr;
        modelTarget[bank][idx] = tgt;
        modelValid[bank][idx] = 1'b1;
    endtask

    // model follows the DUT edge by edge; reads happen before this edge's write
    always @(posedge clk) begin
        if (!rst) begin
            for (int b = 0; b < SLOT_NUM; b++) begin
                for (int i = 0; i < TABLE_ENTRIES; i++) begin
                    modelValid[b][i] = 1'b0;
                end
            end
            modelGhr = '0;
            respPending = 1'b0;
            expQ.delete();
        end else begin
            acceptNow = lookupReq && indexOk;
            if (acceptNow) begin
                newResp = predictBlock(fetchAddr, modelGhr);
                expQ.push_back(newResp);
                for (int k = 0; k < SLOT_NUM; k++) begin
                    lastCkpt[k] = newResp[k*CKPT_W +: CKPT_W];
                end
                lastBlock = {fetchAddr[ADDR_W-1:BLOCK_LSB], {BLOCK_LSB{1'b0}}};
            end
            // repair restores the history and wins over the speculative shift
            if (repairValid) begin
                trainModel(repairAction, repairCheckpoint, repairPc, repairTaken, repairDest);
                modelGhr = {repairCheckpoint[CKPT_W-2 -: HIST_LEN-1], repairTaken};
            end else if (respPending) begin
                modelGhr = {modelGhr[HIST_LEN-2:0], respTakeOr};
            end
            respPending = acceptNow;
            if (acceptNow) begin
                respTakeOr = |newResp[RESP_W-1 -: SLOT_NUM];
            end
        end
    end

    // --------------------
    // response check
    // --------------------

    // sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (lookupValid === 1'b1) begin
            assert (expQ.size() != 0)
                else reportFailure("lookupValid_o went high without an accepted lookup");
            expResp = expQ.pop_front();
            expCkpt = expResp[0 +: SLOT_NUM*CKPT_W];
            ckMask = ckptMask(expCkpt);
            assert (predTake === expResp[RESP_W-1 -: SLOT_NUM])
                else reportFailure($sformatf("error: predTake_o expected %h actual %h",
                                             expResp[RESP_W-1 -: SLOT_NUM], predTake));
            assert (predDest === expResp[SLOT_NUM*CKPT_W +: SLOT_NUM*ADDR_W])
                else reportFailure($sformatf("error: predDest_o expected %h actual %h",
                                             expResp[SLOT_NUM*CKPT_W +: SLOT_NUM*ADDR_W],
                                             predDest));
            assert ((checkpoint & ckMask) === (expCkpt & ckMask))
                else reportFailure($sformatf("error: checkpoint_o expected %h actual %h",
                                             expCkpt & ckMask, checkpoint & ckMask));
            checkedCount++;
        end else begin
            assert (expQ.size() == 0)
                else reportFailure("an accepted lookup got no response in the next cycle");
        end
    end

    // --------------------
    // stimulus
    // --------------------

    task automatic driveCycle(input logic req, input logic ok, input logic [ADDR_W-1:0] addr,
                              input logic rv, input logic [ACT_W-1:0] act,
                              input logic [CKPT_W-1:0] ck, input logic [ADDR_W-1:0] pc,
                              input logic tk, input logic [ADDR_W-1:0] dst);
        @(posedge clk);
        #1;
        lookupReq = req;
        indexOk = ok;
        fetchAddr = addr;
        repairValid = rv;
        repairAction = act;
        repairCheckpoint = ck;
        repairPc = pc;
        repairTaken = tk;
        repairDest = dst;
    endtask

    task automatic driveIdle();
        driveCycle(1'b0, 1'b0, '0, 1'b0, ACT_DIRECTION, '0, '0, 1'b0, '0);
    endtask

    task automatic lookupBlock(input logic [ADDR_W-1:0] addr);
        driveCycle(1'b1, 1'b1, addr, 1'b0, ACT_DIRECTION, '0, '0, 1'b0, '0);
    endtask

    task automatic sendRepair(input logic [ACT_W-1:0] act, input logic [CKPT_W-1:0] ck,
                              input logic [ADDR_W-1:0] pc, input logic tk,
                              input logic [ADDR_W-1:0] dst);
        driveCycle(1'b0, 1'b0, '0, 1'b1, act, ck, pc, tk, dst);
    endtask

    task automatic lookupAndWait(input logic [ADDR_W-1:0] addr);
        lookupBlock(addr);
        driveIdle();
        while (lookupValid !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    // untrained filler block shifts zeros until the history is all zero
    task automatic flushHistory();
        repeat (HIST_LEN) lookupBlock(FILLER);
        driveIdle();
    endtask

    initial begin
        logic [ADDR_W-1:0] addr, dst;
        logic [ACT_W-1:0] act;
        int slot;
        void'($urandom(32'h384a391b));
        checkedCount = 0;
        lookupReq = 1'b0;
        indexOk = 1'b0;
        fetchAddr = '0;
        repairValid = 1'b0;
        repairAction = ACT_DIRECTION;
        repairCheckpoint = '0;
        repairPc = '0;
        repairTaken = 1'b0;
        repairDest = '0;
        wait (rst === 1'b1);

        // fresh blocks predict not-taken
        lookupBlock(32'h0000_1000);
        lookupBlock(32'h0000_2340);
        lookupBlock(32'hABCD_0050);
        driveIdle();

        // target repair on slot 2 then a lookup with the same history
        lookupAndWait(BLOCK_A);
        sendRepair(ACT_TARGET, lastCkpt[2], BLOCK_A | 32'h8, 1'b1, TARGET_ONE);
        flushHistory();
        lookupAndWait(BLOCK_A);

        // counter steps up to saturation, down to zero and back up
        for (int s = 0; s < 8; s++) begin
            flushHistory();
            lookupAndWait(BLOCK_A);
            sendRepair(ACT_DIRECTION, lastCkpt[2], BLOCK_A | 32'h8, STEP_DIR[s], OTHER_DEST);
            flushHistory();
            lookupAndWait(BLOCK_A);
        end

        // back-to-back lookups around a taken shift
        flushHistory();
        repeat (3) lookupBlock(BLOCK_A);
        driveIdle();

        // repair over a pending shift and read of the entry being written
        flushHistory();
        lookupBlock(BLOCK_A);
        driveCycle(1'b1, 1'b1, BLOCK_A, 1'b1, ACT_DIRECTION, lastCkpt[2], BLOCK_A | 32'h8,
                   1'b0, OTHER_DEST);
        lookupBlock(BLOCK_A);
        driveIdle();

        // random mix with index-ok gaps
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            addr = RAND_BASE | ($urandom_range(15, 0) << BLOCK_LSB) | ($urandom_range(1, 0) << 12);
            act = ($urandom_range(1, 0) == 0) ? ACT_DIRECTION : ACT_TARGET;
            slot = $urandom_range(SLOT_NUM - 1, 0);
            dst = $urandom() & 32'hFFFF_FFFC;
            driveCycle($urandom_range(99, 0) < 70, $urandom_range(99, 0) < 80, addr,
                       $urandom_range(99, 0) < 20, act, lastCkpt[slot],
                       lastBlock | ADDR_W'(slot * 4), $urandom_range(1, 0), dst);
        end
        repeat (3) driveIdle();
        @(negedge clk);

        if (expQ.size() != 0 || checkedCount == 0) begin
            reportFailure("lookup responses were missing at the end of the run");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        reportFailure("timeout: the run did not finish in the expected number of cycles");
    end

endmodule

`default_nettype wire

/* verilog/branchPredictTop.sv */
/*
 * Top level of the global-history branch predictor.
 * Joins the history register and the four-bank table; lookups answer
 * one cycle after acceptance, repairs take effect at their edge.
 */
`timescale 1ns/10ps
`default_nettype none

module branchPredictTop
    import fetchPkg::*;
    import predictorPkg::*;
#(
    parameter int HIST_LEN      = 4,
    parameter int TABLE_ENTRIES = 256,
    localparam int CKPT_W       = HIST_LEN + 1 + CTR_W + TARGET_W
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    // lookup strobe
    input  wire logic                       lookupReq_i,
    input  wire logic                       indexOk_i,
    input  wire logic [ADDR_W-1:0]          fetchAddr_i,
    // repair strobe from execute
    input  wire logic                       repairValid_i,
    input  wire logic [ACT_W-1:0]           repairAction_i,
    input  wire logic [CKPT_W-1:0]          repairCheckpoint_i,
    input  wire logic [ADDR_W-1:0]          repairPc_i,
    input  wire logic                       repairTaken_i,
    input  wire logic [ADDR_W-1:0]          repairDest_i,
    // response
    output logic                            lookupValid_o,
    output logic      [SLOT_NUM-1:0]        predTake_o,
    output logic      [SLOT_NUM*ADDR_W-1:0] predDest_o,
    output logic      [SLOT_NUM*CKPT_W-1:0] checkpoint_o
);

    logic [HIST_LEN-1:0] ghr;

    // --------------------
    // history register
    // --------------------

    globalHistoryReg #(
        .HIST_LEN (HIST_LEN)
    ) globalHistoryReg_i (
        .clk           (clk),
        .rst           (rst),
        .specValid_i   (lookupValid_o),
        .predTake_i    (predTake_o),
        .repairValid_i (repairValid_i),
        // history field sits at the top of the checkpoint
        .repairHist_i  (repairCheckpoint_i[CKPT_W-1 -: HIST_LEN]),
        .repairTaken_i (repairTaken_i),
        .ghr_o         (ghr)
    );

    // --------------------
    // table
    // --------------------

    globalHistoryTable #(
        .HIST_LEN      (HIST_LEN),
        .TABLE_ENTRIES (TABLE_ENTRIES)
    ) globalHistoryTable_i (
        .clk                (clk),
        .rst                (rst),
        .lookupReq_i        (lookupReq_i),
        .indexOk_i          (indexOk_i),
        .fetchAddr_i        (fetchAddr_i),
        .ghr_i              (ghr),
        .repairValid_i      (repairValid_i),
        .repairAction_i     (repairAction_i),
        .repairCheckpoint_i (repairCheckpoint_i),
        .repairPc_i         (repairPc_i),
        .repairTaken_i      (repairTaken_i),
        .repairDest_i       (repairDest_i),
        .lookupValid_o      (lookupValid_o),
        .predTake_o         (predTake_o),
        .predDest_o         (predDest_o),
        .checkpoint_o       (checkpoint_o)
    );

endmodule

`default_nettype wire

/* verilog/fetchPkg.sv */
/*
 * Fetch-block geometry shared by the predictor RTL.
 * Modules import it in their header for address and slot widths.
 */
`default_nettype none

package fetchPkg;

    // --------------------
    // address
    // --------------------

    // virtual address, one word
    parameter int ADDR_W = 32;

    // --------------------
    // fetch block
    // --------------------

    // four instruction slots per 16-byte block
    parameter int SLOT_NUM = 4;

    // slot number lives in address bits 3:2
    parameter int SLOT_BITS = 2;

    // first address bit above the block offset
    parameter int BLOCK_LSB = 4;

endpackage

`default_nettype wire

/* verilog/globalHistoryReg.sv */
/*
 * Speculative global history register of the branch predictor.
 * Shifts in the block's taken result after each lookup response;
 * a repair restores it from the checkpoint and takes priority.
 */
`timescale 1ns/10ps
`default_nettype none

module globalHistoryReg
    import fetchPkg::*;
#(
    parameter int HIST_LEN = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                specValid_i,
    input  wire logic [SLOT_NUM-1:0] predTake_i,
    input  wire logic                repairValid_i,
    input  wire logic [HIST_LEN-1:0] repairHist_i,
    input  wire logic                repairTaken_i,
    output logic      [HIST_LEN-1:0] ghr_o
);

    // any taken slot in the block counts as one taken branch
    logic blockTaken;

    assign blockTaken = |predTake_i;

    // --------------------
    // history update
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            ghr_o <= '0;
        end else if (repairValid_i) begin
            // history at the mispredicted branch plus its real outcome
            ghr_o <= {repairHist_i[HIST_LEN-2:0], repairTaken_i};
        end else if (specValid_i) begin
            ghr_o <= {ghr_o[HIST_LEN-2:0], blockTaken};
        end
    end

    // history feeds the table index, so an X here spreads into every bank
    ghrKnown: assert property (
        @(posedge clk) disable iff (!rst) !$isunknown(ghr_o)
    ) else $error("globalHistoryReg: ghr_o unknown after reset");

endmodule

`default_nettype wire

/* verilog/globalHistoryTable.sv */
/*
 * Four-bank global history table with per-bank valid bits.
 * Answers a lookup one cycle after acceptance with taken bits,
 * destinations and checkpoints; trains one entry per repair.
 */
`timescale 1ns/10ps
`default_nettype none

module globalHistoryTable
    import fetchPkg::*;
    import predictorPkg::*;
#(
    parameter int HIST_LEN      = 4,
    parameter int TABLE_ENTRIES = 256,
    localparam int CKPT_W       = HIST_LEN + 1 + CTR_W + TARGET_W
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       lookupReq_i,
    input  wire logic                       indexOk_i,
    input  wire logic [ADDR_W-1:0]          fetchAddr_i,
    input  wire logic [HIST_LEN-1:0]        ghr_i,
    input  wire logic                       repairValid_i,
    input  wire logic [ACT_W-1:0]           repairAction_i,
    input  wire logic [CKPT_W-1:0]          repairCheckpoint_i,
    input  wire logic [ADDR_W-1:0]          repairPc_i,
    input  wire logic                       repairTaken_i,
    input  wire logic [ADDR_W-1:0]          repairDest_i,
    output logic                            lookupValid_o,
    output logic      [SLOT_NUM-1:0]        predTake_o,
    output logic      [SLOT_NUM*ADDR_W-1:0] predDest_o,
    output logic      [SLOT_NUM*CKPT_W-1:0] checkpoint_o
);

    localparam int IDX_W   = $clog2(TABLE_ENTRIES);
    localparam int PC_BITS = IDX_W - HIST_LEN;

    logic                    lookupAcc;
    logic [IDX_W-1:0]        rIdx;
    logic [IDX_W-1:0]        wIdx;
    logic [TABLE_ENTRIES-1:0] validVec [SLOT_NUM];
    logic [SLOT_NUM-1:0]     validQ;
    logic [ADDR_W-BLOCK_LSB-1:0] blockQ;
    logic [HIST_LEN-1:0]     ghrQ;
    logic [ENTRY_W-1:0]      rData [SLOT_NUM];
    logic [SLOT_NUM-1:0]     wEn;

    // repair side
    logic [SLOT_BITS-1:0]    repairBank;
    logic [HIST_LEN-1:0]     ckHist;
    logic                    ckValid;
    logic [CTR_W-1:0]        ckCtr;
    logic [TARGET_W-1:0]     ckTarget;
    logic                    repairWrite;
    logic [CTR_W-1:0]        trainCtr;
    logic [TARGET_W-1:0]     trainTarget;

    // --------------------
    // lookup
    // --------------------

    assign lookupAcc = lookupReq_i && indexOk_i;
    // history high, block address bits low; same index in every bank
    assign rIdx = {ghr_i, fetchAddr_i[BLOCK_LSB +: PC_BITS]};

    always_ff @(posedge clk) begin
        if (!rst) begin
            lookupValid_o <= 1'b0;
        end else begin
            lookupValid_o <= lookupAcc;
        end
    end

    // response payload, sampled alongside the RAM read
    always_ff @(posedge clk) begin
        if (lookupAcc) begin
            blockQ <= fetchAddr_i[ADDR_W-1:BLOCK_LSB];
            ghrQ   <= ghr_i;
            for (int b = 0; b < SLOT_NUM; b++) begin
                validQ[b] <= validVec[b][rIdx];
            end
        end
    end

    // --------------------
    // repair decode
    // --------------------

    assign repairBank = repairPc_i[BLOCK_LSB-1 -: SLOT_BITS];
    assign ckHist     = repairCheckpoint_i[CKPT_W-1 -: HIST_LEN];
    assign ckValid    = repairCheckpoint_i[ENTRY_W];
    assign ckCtr      = repairCheckpoint_i[TARGET_W +: CTR_W];
    assign ckTarget   = repairCheckpoint_i[TARGET_W-1:0];
    assign wIdx       = {ckHist, repairPc_i[BLOCK_LSB +: PC_BITS]};

    assign repairWrite = repairValid_i &&
                         (repairAction_i == ACT_DIRECTION || repairAction_i == ACT_TARGET);

    always_comb begin
        trainCtr    = ckCtr;
        trainTarget = ckTarget;
        if (repairAction_i == ACT_TARGET) begin
            trainCtr    = CTR_WEAK_TAKEN;
            trainTarget = repairDest_i[ADDR_W-1 -: TARGET_W];
        end else if (!ckValid) begin
            // first training, start weak in the resolved direction
            trainCtr    = repairTaken_i ? CTR_WEAK_TAKEN : CTR_WEAK_NOT;
            trainTarget = repairDest_i[ADDR_W-1 -: TARGET_W];
        end else if (repairTaken_i) begin
            if (ckCtr != CTR_MAX) begin
                trainCtr = ckCtr + 1'b1;
            end
        end else if (ckCtr != CTR_MIN) begin
            trainCtr = ckCtr - 1'b1;
        end
    end

    // valid bits, the only table state cleared on reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int b = 0; b < SLOT_NUM; b++) begin
                validVec[b] <= '0;
            end
        end else if (repairWrite) begin
            validVec[repairBank][wIdx] <= 1'b1;
        end
    end

    // --------------------
    // banks and response
    // --------------------

    for (genvar k = 0; k < SLOT_NUM; k++) begin : gBank
        logic [ADDR_W-1:0] slotAddr;

        assign wEn[k] = repairWrite && (repairBank == SLOT_BITS'(k));

        historyRam #(
            .DEPTH (TABLE_ENTRIES),
            .WIDTH (ENTRY_W)
        ) bankRam (
            .clk     (clk),
            .we_i    (wEn[k]),
            .rAddr_i (rIdx),
            .wAddr_i (wIdx),
            .wData_i ({trainCtr, trainTarget}),
            .rData_o (rData[k])
        );

        assign slotAddr = {blockQ, SLOT_BITS'(k), {(BLOCK_LSB-SLOT_BITS){1'b0}}};
        // counter top bit decides direction
        assign predTake_o[k] = validQ[k] && rData[k][ENTRY_W-1];
        assign predDest_o[k*ADDR_W +: ADDR_W] = predTake_o[k] ?
                                                {rData[k][TARGET_W-1:0], 2'b00} :
                                                slotAddr + ADDR_W'(4);
        assign checkpoint_o[k*CKPT_W +: CKPT_W] = {ghrQ, validQ[k], rData[k]};
    end

    // an illegal action would drop a repair silently in the banks
    // while the history register still restores
    actionLegal: assert property (
        @(posedge clk) disable iff (!rst) repairValid_i |-> repairAction_i != '0
    ) else $error("globalHistoryTable: repair with action code 0");

endmodule

`default_nettype wire

/* verilog/historyRam.sv */
/*
 * One-read, one-write synchronous RAM, one per predictor bank.
 * Read-first: a same-edge read and write of one address return old data.
 */
`timescale 1ns/10ps
`default_nettype none

module historyRam #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 32,
    localparam int AW = $clog2(DEPTH)
) (
    input  wire logic             clk,
    input  wire logic             we_i,
    input  wire logic [AW-1:0]    rAddr_i,
    input  wire logic [AW-1:0]    wAddr_i,
    input  wire logic [WIDTH-1:0] wData_i,
    output logic      [WIDTH-1:0] rData_o
);

    // storage, contents undefined until trained
    logic [WIDTH-1:0] mem [DEPTH];

    // --------------------
    // write and read port
    // --------------------

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wAddr_i] <= wData_i;
        end
        // nonblocking read sees the value before this edge's write
        rData_o <= mem[rAddr_i];
    end

    // a write to an unknown address would corrupt the whole bank
    wAddrKnown: assert property (
        @(posedge clk) we_i |-> !$isunknown(wAddr_i)
    ) else $error("historyRam: write address unknown while we_i is high");

endmodule

`default_nettype wire

/* verilog/predictorPkg.sv */
/*
 * Table entry fields, counter encodings and repair action codes.
 * Used by the history table and the top level for checkpoint widths.
 */
`default_nettype none

package predictorPkg;

    // --------------------
    // entry fields
    // --------------------

    // destination without its two zero low bits
    parameter int TARGET_W = 30;

    // two-bit saturating counter
    parameter int CTR_W = 2;

    // one stored entry, counter above target
    parameter int ENTRY_W = CTR_W + TARGET_W;

    // --------------------
    // counter values
    // --------------------

    parameter logic [CTR_W-1:0] CTR_MAX = 2'b11;
    parameter logic [CTR_W-1:0] CTR_MIN = 2'b00;

    // first training of an invalid entry
    parameter logic [CTR_W-1:0] CTR_WEAK_TAKEN = 2'b10;
    parameter logic [CTR_W-1:0] CTR_WEAK_NOT   = 2'b01;

    // --------------------
    // repair actions
    // --------------------

    parameter int ACT_W = 2;

    // code 0 never comes with a valid repair
    parameter logic [ACT_W-1:0] ACT_DIRECTION = 2'd1;
    parameter logic [ACT_W-1:0] ACT_TARGET    = 2'd2;

endpackage

`default_nettype wire
